// File: verilog/fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// operand and single-precision lane widths
`define FPU_DATA_W 64
`define FPU_LANE_W 32

// result forward buses seen by the lane
`define FPU_FWD_N 4

`define FPU_TAG_W 6

// cycles from issue to result
`define FPU_LATENCY 2

// exception enable bits in fpcsr
`define FPU_CSR_INV_EN 11
`define FPU_CSR_DEN_EN 12

`endif

// File: verilog/fpu_pkg.sv
`default_nettype none
`include "fpu_params.svh"

package fpu_pkg;

  // two packed singles with the low lane in bits 31:0
  typedef logic [`FPU_DATA_W-1:0] data_t;
  typedef logic [`FPU_LANE_W-1:0] lane_t;
  typedef logic [`FPU_TAG_W-1:0] tag_t;

  // 0 register operand, 1..4 forward bus 0..3
  typedef logic [2:0] fwd_sel_t;

  // {zero, parity, carry}
  typedef logic [2:0] flags_t;

  // {invalid, denormal}
  typedef logic [1:0] excpt_t;

  // tag followed by the 2-bit cause
  typedef logic [`FPU_TAG_W+1:0] ret_code_t;

  // low two bits double as the unit select
  typedef enum logic [3:0] {
    fop_and       = 4'd0,
    fop_or        = 4'd1,
    fop_xor       = 4'd2,
    fop_andn      = 4'd3,
    fop_copya     = 4'd4,
    fop_swap      = 4'd5,
    fop_dup_lo    = 4'd6,
    fop_dup_hi    = 4'd7,
    fop_cmp_ord   = 4'd8,
    fop_cmp_unord = 4'd9,
    fop_pcmp_eq   = 4'd12,
    fop_pcmp_lt   = 4'd13,
    fop_pcmp_le   = 4'd14
  } fpu_op_e;

endpackage

`default_nettype wire

// File: verilog/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module operand_forward import fpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  data_t    reg_val,
  input  fwd_sel_t sel,
  input  logic     old,
  input  data_t    fwd_bus0,
  input  data_t    fwd_bus1,
  input  data_t    fwd_bus2,
  input  data_t    fwd_bus3,
  output data_t    operand
);

  data_t      bus_cur [`FPU_FWD_N];
  data_t      bus_old [`FPU_FWD_N];
  logic [1:0] idx;

  assign bus_cur[0] = fwd_bus0;
  assign bus_cur[1] = fwd_bus1;
  assign bus_cur[2] = fwd_bus2;
  assign bus_cur[3] = fwd_bus3;

  // bus number from the 1-based select
  assign idx = 2'(sel - 3'd1);

  // bus values from the previous cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FPU_FWD_N; i++) begin
        bus_old[i] <= '0;
      end
    end else begin
      bus_old <= bus_cur;
    end
  end

  always_comb begin
    operand = reg_val;
    if (sel != 3'd0 && sel <= 3'(`FPU_FWD_N)) begin
      operand = old ? bus_old[idx] : bus_cur[idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode import fpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  fpu_op_e    op,
  input  tag_t       tag,
  input  data_t      a_in,
  input  data_t      b_in,
  output logic       logic_en,
  output logic       perm_en,
  output logic       cmp_en,
  output logic [1:0] logic_sel,
  output logic [1:0] perm_sel,
  output logic       cmp_packed,
  output logic       cmp_ordered,
  output logic [1:0] cmp_pred,
  output tag_t       tag_q,
  output data_t      a_q,
  output data_t      b_q,
  output logic       valid_q
);

  fpu_op_e op_q;

  // issue register
  always_ff @(posedge clk) begin
    op_q  <= op;
    tag_q <= tag;
    a_q   <= a_in;
    b_q   <= b_in;
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_comb begin
    logic_en    = 1'b0;
    perm_en     = 1'b0;
    cmp_en      = 1'b0;
    logic_sel   = 2'd0;
    perm_sel    = 2'd0;
    cmp_packed  = 1'b0;
    cmp_ordered = 1'b0;
    cmp_pred    = 2'd0;
    if (valid_q) begin
      case (op_q)
        fop_and, fop_or, fop_xor, fop_andn: begin
          logic_en  = 1'b1;
          logic_sel = op_q[1:0];
        end
        fop_copya, fop_swap, fop_dup_lo, fop_dup_hi: begin
          perm_en  = 1'b1;
          perm_sel = op_q[1:0];
        end
        fop_cmp_ord, fop_cmp_unord: begin
          cmp_en      = 1'b1;
          cmp_ordered = (op_q == fop_cmp_ord);
        end
        fop_pcmp_eq, fop_pcmp_lt, fop_pcmp_le: begin
          cmp_en     = 1'b1;
          cmp_packed = 1'b1;
          // eq 0, lt 1, le 2
          cmp_pred   = op_q[1:0];
        end
        default: begin
          // unknown code issues nothing
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/fp_logic_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_logic_unit import fpu_pkg::*; (
  input  logic       en,
  input  logic [1:0] sel,
  input  data_t      a,
  input  data_t      b,
  output data_t      res
);

  data_t op_res;

  always_comb begin
    case (sel)
      2'd0: begin
        op_res = a & b;
      end
      2'd1: begin
        op_res = a | b;
      end
      2'd2: begin
        op_res = a ^ b;
      end
      default: begin
        // andn clears the bits set in b
        op_res = a & ~b;
      end
    endcase
  end

  // idle unit stays off the merge
  assign res = en ? op_res : '0;

endmodule

`default_nettype wire

// File: verilog/fp_perm_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module fp_perm_unit import fpu_pkg::*; (
  input  logic       en,
  input  logic [1:0] sel,
  input  data_t      a,
  input  data_t      b,
  output data_t      res
);

  lane_t b_lo;
  lane_t b_hi;
  data_t perm;

  assign b_lo = b[`FPU_LANE_W-1:0];
  assign b_hi = b[`FPU_DATA_W-1:`FPU_LANE_W];

  always_comb begin
    case (sel)
      2'd0: begin
        perm = a;
      end
      2'd1: begin
        // singles exchanged
        perm = {b_lo, b_hi};
      end
      2'd2: begin
        perm = {b_lo, b_lo};
      end
      default: begin
        perm = {b_hi, b_hi};
      end
    endcase
  end

  assign res = en ? perm : '0;

endmodule

`default_nettype wire

// File: verilog/fp_compare_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module fp_compare_unit import fpu_pkg::*; (
  input  logic       en,
  input  logic       is_packed,
  input  logic       ordered,
  input  logic [1:0] pred,
  input  data_t      a,
  input  data_t      b,
  output data_t      res,
  output flags_t     flags,
  output excpt_t     raise
);

  lane_t a_lo;
  lane_t a_hi;
  lane_t b_lo;
  lane_t b_hi;

  function automatic logic is_nan(lane_t x);
    return x[30:23] == 8'hff && x[22:0] != '0;
  endfunction

  // quiet bit clear
  function automatic logic is_snan(lane_t x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic logic is_den(lane_t x);
    return x[30:23] == 8'h00 && x[22:0] != '0;
  endfunction

  function automatic logic f_eq(lane_t x, lane_t y);
    // +0 and -0 match
    return !is_nan(x) && !is_nan(y) && (x == y || (x[30:0] == '0 && y[30:0] == '0));
  endfunction

  function automatic logic f_lt(lane_t x, lane_t y);
    if (is_nan(x) || is_nan(y) || (x[30:0] == '0 && y[30:0] == '0)) begin
      return 1'b0;
    end
    if (x[31] != y[31]) begin
      return x[31];
    end
    // negatives order reversed in sign-magnitude
    return x[31] ? (x[30:0] > y[30:0]) : (x[30:0] < y[30:0]);
  endfunction

  function automatic logic pred_hit(logic [1:0] p, lane_t x, lane_t y);
    case (p)
      2'd0: return f_eq(x, y);
      2'd1: return f_lt(x, y);
      2'd2: return f_lt(x, y) || f_eq(x, y);
      default: return 1'b0;
    endcase
  endfunction

  assign a_lo = a[`FPU_LANE_W-1:0];
  assign a_hi = a[`FPU_DATA_W-1:`FPU_LANE_W];
  assign b_lo = b[`FPU_LANE_W-1:0];
  assign b_hi = b[`FPU_DATA_W-1:`FPU_LANE_W];

  always_comb begin
    res   = '0;
    flags = '0;
    raise = '0;
    if (en && is_packed) begin
      res = {{`FPU_LANE_W{pred_hit(pred, a_hi, b_hi)}},
             {`FPU_LANE_W{pred_hit(pred, a_lo, b_lo)}}};
      raise[1] = is_snan(a_lo) || is_snan(a_hi) || is_snan(b_lo) || is_snan(b_hi);
      raise[0] = is_den(a_lo) || is_den(a_hi) || is_den(b_lo) || is_den(b_hi);
    end else if (en) begin
      if (is_nan(a_lo) || is_nan(b_lo)) begin
        flags = 3'b111;
      end else if (f_lt(a_lo, b_lo)) begin
        flags = 3'b001;
      end else if (f_eq(a_lo, b_lo)) begin
        flags = 3'b100;
      end
      // ordered form traps on any nan
      raise[1] = ordered ? (is_nan(a_lo) || is_nan(b_lo)) : (is_snan(a_lo) || is_snan(b_lo));
      raise[0] = is_den(a_lo) || is_den(b_lo);
    end
  end

endmodule

`default_nettype wire

// File: verilog/fp_retire.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module fp_retire import fpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_q,
  input  tag_t        tag_q,
  input  data_t       logic_res,
  input  data_t       perm_res,
  input  data_t       cmp_res,
  input  flags_t      cmp_flags,
  input  excpt_t      cmp_raise,
  input  logic [31:0] fpcsr,
  output logic        res_valid,
  output data_t       res,
  output flags_t      flags,
  output logic        ret_en,
  output ret_code_t   ret_code
);

  data_t  merged;
  excpt_t enabled;
  logic   trap;

  // idle units drive zero
  assign merged = logic_res | perm_res | cmp_res;

  assign enabled = cmp_raise & {fpcsr[`FPU_CSR_INV_EN], fpcsr[`FPU_CSR_DEN_EN]};
  assign trap    = valid_q && (enabled != '0);

  always_ff @(posedge clk) begin
    res   <= merged;
    flags <= cmp_flags;
    if (rst) begin
      res_valid <= 1'b0;
      ret_en    <= 1'b0;
      ret_code  <= '0;
    end else begin
      res_valid <= valid_q;
      ret_en    <= trap;
      ret_code  <= trap ? {tag_q, enabled} : '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_lane import fpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  fpu_op_e     op,
  input  tag_t        tag,
  input  data_t       a,
  input  data_t       b,
  input  fwd_sel_t    a_sel,
  input  fwd_sel_t    b_sel,
  input  logic        a_old,
  input  logic        b_old,
  input  data_t       fwd_bus0,
  input  data_t       fwd_bus1,
  input  data_t       fwd_bus2,
  input  data_t       fwd_bus3,
  input  logic [31:0] fpcsr,
  output logic        res_valid,
  output data_t       res,
  output flags_t      flags,
  output logic        ret_en,
  output ret_code_t   ret_code
);

  data_t      a_fwd;
  data_t      b_fwd;
  logic       logic_en;
  logic       perm_en;
  logic       cmp_en;
  logic [1:0] logic_sel;
  logic [1:0] perm_sel;
  logic       cmp_packed;
  logic       cmp_ordered;
  logic [1:0] cmp_pred;
  tag_t       tag_q;
  data_t      a_q;
  data_t      b_q;
  logic       valid_q;
  data_t      logic_res;
  data_t      perm_res;
  data_t      cmp_res;
  flags_t     cmp_flags;
  excpt_t     cmp_raise;

  operand_forward u_a_fwd (
    .clk(clk), .rst(rst), .reg_val(a), .sel(a_sel), .old(a_old),
    .fwd_bus0(fwd_bus0), .fwd_bus1(fwd_bus1), .fwd_bus2(fwd_bus2), .fwd_bus3(fwd_bus3),
    .operand(a_fwd)
  );

  operand_forward u_b_fwd (
    .clk(clk), .rst(rst), .reg_val(b), .sel(b_sel), .old(b_old),
    .fwd_bus0(fwd_bus0), .fwd_bus1(fwd_bus1), .fwd_bus2(fwd_bus2), .fwd_bus3(fwd_bus3),
    .operand(b_fwd)
  );

  op_decode u_decode (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .tag(tag),
    .a_in(a_fwd), .b_in(b_fwd),
    .logic_en(logic_en), .perm_en(perm_en), .cmp_en(cmp_en),
    .logic_sel(logic_sel), .perm_sel(perm_sel),
    .cmp_packed(cmp_packed), .cmp_ordered(cmp_ordered), .cmp_pred(cmp_pred),
    .tag_q(tag_q), .a_q(a_q), .b_q(b_q), .valid_q(valid_q)
  );

  fp_logic_unit u_logic (
    .en(logic_en), .sel(logic_sel), .a(a_q), .b(b_q), .res(logic_res)
  );

  fp_perm_unit u_perm (
    .en(perm_en), .sel(perm_sel), .a(a_q), .b(b_q), .res(perm_res)
  );

  fp_compare_unit u_cmp (
    .en(cmp_en), .is_packed(cmp_packed), .ordered(cmp_ordered), .pred(cmp_pred),
    .a(a_q), .b(b_q), .res(cmp_res), .flags(cmp_flags), .raise(cmp_raise)
  );

  fp_retire u_retire (
    .clk(clk), .rst(rst), .valid_q(valid_q), .tag_q(tag_q),
    .logic_res(logic_res), .perm_res(perm_res), .cmp_res(cmp_res),
    .cmp_flags(cmp_flags), .cmp_raise(cmp_raise), .fpcsr(fpcsr),
    .res_valid(res_valid), .res(res), .flags(flags),
    .ret_en(ret_en), .ret_code(ret_code)
  );

endmodule

`default_nettype wire

// File: bench/fpu_lane_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module fpu_lane_assert (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic res_valid,
  input logic ret_en
);

  // every issue comes back after the pipeline latency
  property issue_gives_result;
    @(posedge clk) disable iff (rst) in_valid |-> ##`FPU_LATENCY res_valid;
  endproperty

  // and nothing comes back without an issue
  property result_needs_issue;
    @(posedge clk) disable iff (rst) res_valid |-> $past(in_valid, `FPU_LATENCY);
  endproperty

  property trap_with_result;
    @(posedge clk) ret_en |-> res_valid;
  endproperty

  property quiet_in_reset;
    @(posedge clk) rst |=> !res_valid && !ret_en;
  endproperty

  a_issue_gives_result: assert property (issue_gives_result)
    else $error("res_valid missing after in_valid");
  a_result_needs_issue: assert property (result_needs_issue)
    else $error("res_valid without a matching in_valid");
  a_trap_with_result: assert property (trap_with_result)
    else $error("ret_en without res_valid");
  a_quiet_in_reset: assert property (quiet_in_reset)
    else $error("outputs active during reset");

endmodule

`default_nettype wire

// File: bench/fpu_lane_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_params.svh"

module fpu_lane_tb import fpu_pkg::*; ();

  localparam int DRAIN_LIMIT = 50;

  logic        clk;
  logic        rst;
  logic        in_valid;
  fpu_op_e     op;
  tag_t        tag;
  data_t       a;
  data_t       b;
  fwd_sel_t    a_sel;
  fwd_sel_t    b_sel;
  logic        a_old;
  logic        b_old;
  data_t       fwd_bus0;
  data_t       fwd_bus1;
  data_t       fwd_bus2;
  data_t       fwd_bus3;
  logic [31:0] fpcsr;
  logic        res_valid;
  data_t       res;
  flags_t      flags;
  logic        ret_en;
  ret_code_t   ret_code;

  int          errors;
  int          issued;
  int          checked;
  logic [1:0]  valid_hist;
  data_t       exp_res_q[$];
  flags_t      exp_flags_q[$];
  logic        exp_ret_en_q[$];
  ret_code_t   exp_code_q[$];

  fpu_lane u_fpu_lane (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .tag(tag),
    .a(a), .b(b), .a_sel(a_sel), .b_sel(b_sel), .a_old(a_old), .b_old(b_old),
    .fwd_bus0(fwd_bus0), .fwd_bus1(fwd_bus1), .fwd_bus2(fwd_bus2), .fwd_bus3(fwd_bus3),
    .fpcsr(fpcsr), .res_valid(res_valid), .res(res), .flags(flags),
    .ret_en(ret_en), .ret_code(ret_code)
  );

  bind fpu_lane fpu_lane_assert u_lane_assert (
    .clk(clk), .rst(rst), .in_valid(in_valid), .res_valid(res_valid), .ret_en(ret_en)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_result();
    data_t     e_res;
    flags_t    e_flags;
    logic      e_ret_en;
    ret_code_t e_code;
    e_res    = exp_res_q.pop_front();
    e_flags  = exp_flags_q.pop_front();
    e_ret_en = exp_ret_en_q.pop_front();
    e_code   = exp_code_q.pop_front();
    check_value("res", e_res, res);
    check_value("flags", 64'(e_flags), 64'(flags));
    check_value("ret_en", 64'(e_ret_en), 64'(ret_en));
    check_value("ret_code", 64'(e_code), 64'(ret_code));
    checked++;
  endtask

  // outputs sampled on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      valid_hist = 2'b00;
      check_value("res_valid", 64'd0, 64'(res_valid));
      check_value("ret_en", 64'd0, 64'(ret_en));
    end else begin
      check_value("res_valid", 64'(valid_hist[1]), 64'(res_valid));
      if (valid_hist[1]) begin
        if (exp_res_q.size() == 0) begin
          errors++;
          $display("a result came back with no operation waiting for it");
        end else begin
          compare_result();
        end
      end else begin
        check_value("ret_en", 64'd0, 64'(ret_en));
      end
      valid_hist = {valid_hist[0], in_valid};
    end
  end

  task automatic run_vectors(input int fd);
    string     line;
    int        n;
    logic [3:0] v_op;
    tag_t      v_tag;
    data_t     v_a;
    data_t     v_b;
    fwd_sel_t  v_asel;
    fwd_sel_t  v_bsel;
    logic      v_aold;
    logic      v_bold;
    data_t     v_bus0;
    data_t     v_bus1;
    data_t     v_bus2;
    data_t     v_bus3;
    logic [31:0] v_fpcsr;
    int        v_gap;
    data_t     v_res;
    flags_t    v_flags;
    logic      v_ret_en;
    ret_code_t v_code;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "/") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h",
                    v_op, v_tag, v_a, v_b, v_asel, v_aold, v_bsel, v_bold,
                    v_bus0, v_bus1, v_bus2, v_bus3, v_fpcsr, v_gap,
                    v_res, v_flags, v_ret_en, v_code);
        if (n != 18) begin
          errors++;
          $display("vector line could not be read: %s", line);
        end else begin
          @(posedge clk);
          in_valid <= 1'b1;
          op       <= fpu_op_e'(v_op);
          tag      <= v_tag;
          a        <= v_a;
          b        <= v_b;
          a_sel    <= v_asel;
          a_old    <= v_aold;
          b_sel    <= v_bsel;
          b_old    <= v_bold;
          fwd_bus0 <= v_bus0;
          fwd_bus1 <= v_bus1;
          fwd_bus2 <= v_bus2;
          fwd_bus3 <= v_bus3;
          fpcsr    <= v_fpcsr;
          exp_res_q.push_back(v_res);
          exp_flags_q.push_back(v_flags);
          exp_ret_en_q.push_back(v_ret_en);
          exp_code_q.push_back(v_code);
          issued++;
          // idle cycles hold the buses and fpcsr
          for (int i = 0; i < v_gap; i++) begin
            @(posedge clk);
            in_valid <= 1'b0;
          end
        end
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  initial begin
    int fd;
    int waited;
    errors     = 0;
    issued     = 0;
    checked    = 0;
    valid_hist = 2'b00;
    rst        = 1'b1;
    in_valid   = 1'b0;
    op         = fop_and;
    tag        = '0;
    a          = '0;
    b          = '0;
    a_sel      = '0;
    b_sel      = '0;
    a_old      = 1'b0;
    b_old      = 1'b0;
    fwd_bus0   = '0;
    fwd_bus1   = '0;
    fwd_bus2   = '0;
    fwd_bus3   = '0;
    fpcsr      = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("bench/fpu_lane_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("vector file bench/fpu_lane_vectors.txt could not be opened");
    end else begin
      run_vectors(fd);
      $fclose(fd);
    end

    waited = 0;
    while (exp_res_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_res_q.size() != 0) begin
      errors++;
      $display("timed out with %0d results still outstanding", exp_res_q.size());
    end
    // a few idle cycles to catch stray outputs
    repeat (4) @(posedge clk);

    $display("%0d issued, %0d checked, %0d errors", issued, checked, errors);
    if (errors == 0 && checked == issued && issued > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/operand_forward.sv
verilog/op_decode.sv
verilog/fp_logic_unit.sv
verilog/fp_perm_unit.sv
verilog/fp_compare_unit.sv
verilog/fp_retire.sv
verilog/fpu_lane.sv
bench/fpu_lane_assert.sv
bench/fpu_lane_tb.sv

// File: bench/fpu_lane_vectors.txt
// op tag a b a_sel a_old b_sel b_old bus0 bus1 bus2 bus3 fpcsr gap(dec) | res flags ret_en ret_code
// all hex except gap; flags are {zero,parity,carry}
0 00 ff00ff00f0f0f0f0 0ff00ff0cccccccc 0 0 0 0 0 0 0 0 0 0 0f000f00c0c0c0c0 0 0 00
1 01 ff00ff00f0f0f0f0 0ff00ff0cccccccc 0 0 0 0 0 0 0 0 0 0 fff0fff0fcfcfcfc 0 0 00
2 02 ff00ff00f0f0f0f0 0ff00ff0cccccccc 0 0 0 0 0 0 0 0 0 0 f0f0f0f03c3c3c3c 0 0 00
3 03 ff00ff00f0f0f0f0 0ff00ff0cccccccc 0 0 0 0 0 0 0 0 0 0 f000f00030303030 0 0 00
4 04 1111111122222222 3333333344444444 0 0 0 0 0 0 0 0 0 0 1111111122222222 0 0 00
5 05 1111111122222222 3333333344444444 0 0 0 0 0 0 0 0 0 0 4444444433333333 0 0 00
6 06 1111111122222222 3333333344444444 0 0 0 0 0 0 0 0 0 0 4444444444444444 0 0 00
7 07 1111111122222222 3333333344444444 0 0 0 0 0 0 0 0 0 2 3333333333333333 0 0 00
1 08 0 0 1 0 0 0 1000000000000001 1100000000000011 1200000000000021 1300000000000031 0 0 1000000000000001 0 0 00
1 09 0 0 1 1 0 0 2000000000000002 2100000000000012 2200000000000022 2300000000000032 0 0 1000000000000001 0 0 00
1 0a 0 0 2 0 0 0 3000000000000003 3100000000000013 3200000000000023 3300000000000033 0 0 3100000000000013 0 0 00
1 0b 0 0 2 1 0 0 4000000000000004 4100000000000014 4200000000000024 4300000000000034 0 0 3100000000000013 0 0 00
1 0c 0 0 0 0 3 0 5000000000000005 5100000000000015 5200000000000025 5300000000000035 0 0 5200000000000025 0 0 00
1 0d 0 0 0 0 3 1 6000000000000006 6100000000000016 6200000000000026 6300000000000036 0 0 5200000000000025 0 0 00
1 0e 0 0 0 0 4 0 7000000000000007 7100000000000017 7200000000000027 7300000000000037 0 0 7300000000000037 0 0 00
1 0f 0 0 4 1 1 0 8000000000000008 8100000000000018 8200000000000028 8300000000000038 0 2 f30000000000003f 0 0 00
8 10 3f800000 40000000 0 0 0 0 0 0 0 0 0 0 0 1 0 00
8 11 40000000 40000000 0 0 0 0 0 0 0 0 0 0 0 4 0 00
8 12 40000000 bf800000 0 0 0 0 0 0 0 0 0 0 0 0 0 00
9 13 bf800000 3f800000 0 0 0 0 0 0 0 0 0 0 0 1 0 00
9 14 0 80000000 0 0 0 0 0 0 0 0 0 0 0 4 0 00
9 15 7fc00000 3f800000 0 0 0 0 0 0 0 0 0 0 0 7 0 00
8 16 3f800000 7fc00000 0 0 0 0 0 0 0 0 0 0 0 7 0 00
8 17 c0000000 bf800000 0 0 0 0 0 0 0 0 0 2 0 1 0 00
c 18 3f80000040000000 3f8000003f800000 0 0 0 0 0 0 0 0 0 0 ffffffff00000000 0 0 00
d 19 3f8000003f800000 bf80000040000000 0 0 0 0 0 0 0 0 0 0 00000000ffffffff 0 0 00
e 1a 400000003f800000 4000000040000000 0 0 0 0 0 0 0 0 0 0 ffffffffffffffff 0 0 00
e 1b 7fc0000040000000 3f8000003f800000 0 0 0 0 0 0 0 0 0 0 0 0 0 00
c 1c 7fc0000000000000 7fc0000080000000 0 0 0 0 0 0 0 0 0 0 00000000ffffffff 0 0 00
d 1d 00000000c0000000 80000000bf800000 0 0 0 0 0 0 0 0 0 2 00000000ffffffff 0 0 00
8 20 3f800000 7fc00000 0 0 0 0 0 0 0 0 0800 1 0 7 1 82
8 21 3f800000 7fc00000 0 0 0 0 0 0 0 0 1000 1 0 7 0 00
9 22 7f800001 3f800000 0 0 0 0 0 0 0 0 0800 1 0 7 1 8a
9 23 7fc00000 3f800000 0 0 0 0 0 0 0 0 1800 1 0 7 0 00
8 24 00000001 3f800000 0 0 0 0 0 0 0 0 1000 1 0 1 1 91
8 25 00000001 3f800000 0 0 0 0 0 0 0 0 0800 1 0 1 0 00
c 26 7f8000013f800000 3f80000000000001 0 0 0 0 0 0 0 0 1800 1 0 0 1 9b
8 27 7f8000013f800000 000000013f800000 0 0 0 0 0 0 0 0 1800 1 0 4 0 00
d 28 3f8000003f800000 4000000040000000 0 0 0 0 0 0 0 0 1800 1 ffffffffffffffff 0 0 00
0 29 ffffffffffffffff 0123456789abcdef 0 0 0 0 0 0 0 0 1800 1 0123456789abcdef 0 0 00
8 3f 7fc00000 7fc00000 0 0 0 0 0 0 0 0 0800 1 0 7 1 fe
8 2a 7fc00000 3f800000 0 0 0 0 0 0 0 0 0800 0 0 7 1 aa
1 2b 1 2 0 0 0 0 0 0 0 0 0800 4 3 0 0 00
